//--- test/frontend_trace.txt
# U pc cond taken target | F redirect_pc | R ready_pattern | W cycles | M miss_count
# E pc slot_valid npc0 npc1   (all hex except W and M)
R ff
E 00001000 3 00001004 00001008
E 00001008 3 0000100c 00001010
E 00001010 3 00001014 00001018
F 00001000
E 00001000 3 00001004 00001008
E 00001008 3 0000100c 00001010
M 2
U 00001008 0 1 00001100
F 00001008
E 00001008 1 00001100 00000000
E 00001100 3 00001104 00001108
U 00001010 1 1 00001200
F 00001010
E 00001010 1 00001200 00000000
E 00001200 3 00001204 00001208
U 00001010 1 0 00000000
U 00001010 1 0 00000000
F 00001010
E 00001010 3 00001014 00001018
F 00003000
W 3
F 00002004
E 00002004 2 00000000 00002008
R a5
E 00002008 3 0000200c 00002010
E 00002010 3 00002014 00002018
R 31
E 00002018 3 0000201c 00002020
E 00002020 3 00002024 00002028
E 00002028 3 0000202c 00002030

//--- tb.f
source/frontend_pkg.sv
source/bpu.sv
source/icache.sv
source/ifu.sv
source/frontend.sv
test/frontend_properties.sv
test/tb_frontend.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - source/frontend_pkg.sv
  - source/bpu.sv
  - source/icache.sv
  - source/ifu.sv
  - source/frontend.sv
  - target: test
    files:
      - test/frontend_properties.sv
      - test/tb_frontend.sv

//--- test/tb_frontend.sv
// Fetch frontend testbench
module tb_frontend;
  import frontend_pkg::*;

  logic                             clk_i;
  logic                             rst_i;
  logic                             ibuffer_valid_o;
  logic                             ibuffer_ready_i;
  logic [FETCH_WIDTH-1:0][ILEN-1:0] ibuffer_data_o;
  logic [PLEN-1:0]                  ibuffer_pc_o;
  logic [FETCH_WIDTH-1:0]           ibuffer_slot_valid_o;
  logic [FETCH_WIDTH-1:0][PLEN-1:0] ibuffer_pred_npc_o;
  logic                             flush_i;
  logic [PLEN-1:0]                  redirect_pc_i;
  logic                             bpu_update_valid_i;
  logic [PLEN-1:0]                  bpu_update_pc_i;
  logic                             bpu_update_is_cond_i;
  logic                             bpu_update_taken_i;
  logic [PLEN-1:0]                  bpu_update_target_i;
  logic                             miss_req_valid_o;
  logic                             miss_req_ready_i;
  logic [PLEN-1:0]                  miss_req_paddr_o;
  logic                             refill_valid_i;
  logic                             refill_ready_o;
  logic [PLEN-1:0]                  refill_paddr_i;
  logic [LINE_BITS-1:0]             refill_data_i;

  localparam int TIMEOUT_CYCLES = 5000;
  localparam logic [ILEN-1:0] MEM_XOR = 32'h5A5A_0000;

  integer     seed = 32'ha1b6_acb7;
  int         miss_count;
  logic [7:0] ready_pat;
  int         ready_idx;

  frontend UUT (.*);

  // Clock, period 40
  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // Report a mismatch and stop
  task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("FAILED %s: actual %h expected %h", name, act, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // Trace line that does not parse
  task automatic stop_on_bad_line(input string text);
    $display("Unreadable line in the trace file: %s", text);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // ====================================================================
  // Memory model for misses and refills
  // ====================================================================
  initial begin
    logic [PLEN-1:0] line_addr;
    int              delay;
    int              cnt;
    @(negedge rst_i);
    forever begin
      // Request seen at the rising edge the DUT samples
      cnt = 0;
      @(posedge clk_i);
      while (!miss_req_valid_o) begin
        cnt++;
        if (cnt > TIMEOUT_CYCLES)
          stop_on_timeout("a miss request");
        @(posedge clk_i);
      end
      line_addr = miss_req_paddr_o;
      miss_count++;
      // Ready one cycle late, so the request must hold
      @(negedge clk_i);
      miss_req_ready_i = 1'b1;
      @(negedge clk_i);
      miss_req_ready_i = 1'b0;
      delay = 1 + ($unsigned($random(seed)) % 4);
      repeat (delay) @(negedge clk_i);
      cnt = 0;
      while (!refill_ready_o) begin
        cnt++;
        if (cnt > TIMEOUT_CYCLES)
          stop_on_timeout("refill ready");
        @(negedge clk_i);
      end
      refill_valid_i = 1'b1;
      refill_paddr_i = line_addr;
      for (int w = 0; w < LINE_BITS / ILEN; w++)
        refill_data_i[w*ILEN +: ILEN] = (line_addr + 4 * w) ^ MEM_XOR;
      @(negedge clk_i);
      refill_valid_i = 1'b0;
    end
  end

  // ====================================================================
  // Trace commands
  // ====================================================================
  task automatic send_update(input logic [31:0] pc, input logic cond, input logic taken,
                             input logic [31:0] target);
    bpu_update_valid_i   = 1'b1;
    bpu_update_pc_i      = pc;
    bpu_update_is_cond_i = cond;
    bpu_update_taken_i   = taken;
    bpu_update_target_i  = target;
    @(negedge clk_i);
    bpu_update_valid_i = 1'b0;
  endtask

  task automatic send_flush(input logic [31:0] pc);
    flush_i       = 1'b1;
    redirect_pc_i = pc;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  // Sink one group under the ready pattern, then compare it
  task automatic expect_group(input logic [31:0] pc, input logic [1:0] sv,
                              input logic [31:0] npc0, input logic [31:0] npc1);
    logic [31:0] base;
    logic [31:0] npc [2];
    int          cnt;
    cnt    = 0;
    npc[0] = npc0;
    npc[1] = npc1;
    base   = pc & ~32'h7;
    forever begin
      ibuffer_ready_i = ready_pat[ready_idx % 8];
      ready_idx++;
      if (ibuffer_valid_o && ibuffer_ready_i)
        break;
      cnt++;
      if (cnt > TIMEOUT_CYCLES)
        stop_on_timeout("an instruction group");
      @(negedge clk_i);
    end
    check_value("ibuffer_pc_o", ibuffer_pc_o, pc);
    check_value("ibuffer_slot_valid_o", 32'(ibuffer_slot_valid_o), 32'(sv));
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      check_value($sformatf("ibuffer_data_o[%0d]", k), ibuffer_data_o[k],
                  (base + 4 * k) ^ MEM_XOR);
      if (sv[k])
        check_value($sformatf("ibuffer_pred_npc_o[%0d]", k), ibuffer_pred_npc_o[k], npc[k]);
    end
    @(negedge clk_i);
    ibuffer_ready_i = 1'b0;
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    rst_i                = 1'b1;
    ibuffer_ready_i      = 1'b0;
    flush_i              = 1'b0;
    redirect_pc_i        = '0;
    bpu_update_valid_i   = 1'b0;
    bpu_update_pc_i      = '0;
    bpu_update_is_cond_i = 1'b0;
    bpu_update_taken_i   = 1'b0;
    bpu_update_target_i  = '0;
    miss_req_ready_i     = 1'b0;
    refill_valid_i       = 1'b0;
    refill_paddr_i       = '0;
    refill_data_i        = '0;
    miss_count           = 0;
    ready_pat            = 8'hff;
    ready_idx            = 0;
    fd = $fopen("test/frontend_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file");
      $display("Simulation FAILED");
      $fatal(1);
    end
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    while ($fgets(line, fd)) begin
      if (line.len() < 2 || line[0] == "#")
        continue;
      case (line[0])
        "U": begin
          n = $sscanf(line, "U %h %h %h %h", a, b, c, d);
          if (n != 4)
            stop_on_bad_line(line);
          send_update(a, b[0], c[0], d);
        end
        "F": begin
          n = $sscanf(line, "F %h", a);
          if (n != 1)
            stop_on_bad_line(line);
          send_flush(a);
        end
        "R": begin
          n = $sscanf(line, "R %h", a);
          if (n != 1)
            stop_on_bad_line(line);
          ready_pat = a[7:0];
          ready_idx = 0;
        end
        "W": begin
          n = $sscanf(line, "W %d", a);
          if (n != 1)
            stop_on_bad_line(line);
          repeat (a) @(negedge clk_i);
        end
        "M": begin
          n = $sscanf(line, "M %d", a);
          if (n != 1)
            stop_on_bad_line(line);
          check_value("miss request count", miss_count, a);
        end
        "E": begin
          n = $sscanf(line, "E %h %h %h %h", a, b, c, d);
          if (n != 4)
            stop_on_bad_line(line);
          expect_group(a, b[1:0], c, d);
        end
        default: begin
          stop_on_bad_line(line);
        end
      endcase
    end
    $fclose(fd);
    $display("Simulation PASSED");
    $finish;
  end

endmodule : tb_frontend

//--- test/frontend_properties.sv
// Frontend handshake assertions
module frontend_properties (
  input logic                          clk_i,
  input logic                          rst_i,
  input logic                          flush_i,
  input logic                          ibuffer_valid_o,
  input logic                          ibuffer_ready_i,
  input logic [frontend_pkg::PLEN-1:0] ibuffer_pc_o,
  input logic [63:0]                   ibuffer_data_o,
  input logic [1:0]                    ibuffer_slot_valid_o,
  input logic [63:0]                   ibuffer_pred_npc_o,
  input logic                          miss_req_valid_o,
  input logic                          miss_req_ready_i,
  input logic [frontend_pkg::PLEN-1:0] miss_req_paddr_o,
  input logic                          refill_valid_i,
  input logic                          refill_ready_o
);
  // Set between miss handshake and refill handshake
  logic miss_open_q;

  always_ff @(posedge clk_i) begin
    if (rst_i)
      miss_open_q <= 1'b0;
    else if (miss_req_valid_o && miss_req_ready_i)
      miss_open_q <= 1'b1;
    else if (refill_valid_i && refill_ready_o)
      miss_open_q <= 1'b0;
  end

  // Group fields hold while the backend stalls
  assert property (@(posedge clk_i) disable iff (rst_i)
    ibuffer_valid_o && !ibuffer_ready_i && !flush_i |=> ibuffer_valid_o &&
    $stable(ibuffer_pc_o) && $stable(ibuffer_data_o) &&
    $stable(ibuffer_slot_valid_o) && $stable(ibuffer_pred_npc_o))
    else $error("instruction buffer group changed under back-pressure");

  assert property (@(posedge clk_i) disable iff (rst_i)
    miss_req_valid_o && !miss_req_ready_i |=> miss_req_valid_o && $stable(miss_req_paddr_o))
    else $error("miss request dropped before ready");

  assert property (@(posedge clk_i) disable iff (rst_i)
    refill_ready_o |-> miss_open_q)
    else $error("refill ready outside a miss");

endmodule : frontend_properties

bind frontend frontend_properties i_frontend_properties (.*);

//--- source/frontend.sv
// Instruction fetch frontend top
module frontend (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  // ====================================================================
  // Instruction buffer and backend control
  // ====================================================================
  output logic                                     ibuffer_valid_o,
  input  logic                                     ibuffer_ready_i,
  output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::ILEN-1:0] ibuffer_data_o,
  output logic [frontend_pkg::PLEN-1:0]            ibuffer_pc_o,
  output logic [frontend_pkg::FETCH_WIDTH-1:0]     ibuffer_slot_valid_o,
  output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::PLEN-1:0] ibuffer_pred_npc_o,
  input  logic                                     flush_i,
  input  logic [frontend_pkg::PLEN-1:0]            redirect_pc_i,
  input  logic                                     bpu_update_valid_i,
  input  logic [frontend_pkg::PLEN-1:0]            bpu_update_pc_i,
  input  logic                                     bpu_update_is_cond_i,
  input  logic                                     bpu_update_taken_i,
  input  logic [frontend_pkg::PLEN-1:0]            bpu_update_target_i,
  // ====================================================================
  // Memory side
  // ====================================================================
  output logic                                     miss_req_valid_o,
  input  logic                                     miss_req_ready_i,
  output logic [frontend_pkg::PLEN-1:0]            miss_req_paddr_o,
  input  logic                                     refill_valid_i,
  output logic                                     refill_ready_o,
  input  logic [frontend_pkg::PLEN-1:0]            refill_paddr_i,
  input  logic [frontend_pkg::LINE_BITS-1:0]       refill_data_i
);
  import frontend_pkg::*;

  // Fetch request to both lookups
  logic            fetch_req;
  logic [PLEN-1:0] fetch_pc;
  logic            kill;
  // Predictor answer
  logic                       pred_valid;
  logic                       pred_taken;
  logic [FETCH_SLOT_BITS-1:0] pred_slot;
  logic [PLEN-1:0]            pred_target;
  // Cache answer
  logic                             rsp_valid;
  logic [FETCH_WIDTH-1:0][ILEN-1:0] rsp_data;

  ifu i_ifu (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .flush_i             (flush_i),
    .redirect_pc_i       (redirect_pc_i),
    .fetch_req_o         (fetch_req),
    .fetch_pc_o          (fetch_pc),
    .kill_o              (kill),
    .pred_valid_i        (pred_valid),
    .pred_taken_i        (pred_taken),
    .pred_slot_i         (pred_slot),
    .pred_target_i       (pred_target),
    .rsp_valid_i         (rsp_valid),
    .rsp_data_i          (rsp_data),
    .ibuffer_valid_o     (ibuffer_valid_o),
    .ibuffer_ready_i     (ibuffer_ready_i),
    .ibuffer_pc_o        (ibuffer_pc_o),
    .ibuffer_data_o      (ibuffer_data_o),
    .ibuffer_slot_valid_o(ibuffer_slot_valid_o),
    .ibuffer_pred_npc_o  (ibuffer_pred_npc_o)
  );

  bpu i_bpu (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_req_i     (fetch_req),
    .fetch_pc_i      (fetch_pc),
    .update_valid_i  (bpu_update_valid_i),
    .update_pc_i     (bpu_update_pc_i),
    .update_is_cond_i(bpu_update_is_cond_i),
    .update_taken_i  (bpu_update_taken_i),
    .update_target_i (bpu_update_target_i),
    .pred_valid_o    (pred_valid),
    .pred_taken_o    (pred_taken),
    .pred_slot_o     (pred_slot),
    .pred_target_o   (pred_target)
  );

  icache i_icache (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_req_i     (fetch_req),
    .fetch_pc_i      (fetch_pc),
    .kill_i          (kill),
    .rsp_valid_o     (rsp_valid),
    .rsp_data_o      (rsp_data),
    .miss_req_valid_o(miss_req_valid_o),
    .miss_req_ready_i(miss_req_ready_i),
    .miss_req_paddr_o(miss_req_paddr_o),
    .refill_valid_i  (refill_valid_i),
    .refill_ready_o  (refill_ready_o),
    .refill_paddr_i  (refill_paddr_i),
    .refill_data_i   (refill_data_i)
  );

endmodule : frontend

//--- source/ifu.sv
// Instruction fetch unit
module ifu (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     flush_i,
  input  logic [frontend_pkg::PLEN-1:0]            redirect_pc_i,
  output logic                                     fetch_req_o,
  output logic [frontend_pkg::PLEN-1:0]            fetch_pc_o,
  output logic                                     kill_o,
  input  logic                                     pred_valid_i,
  input  logic                                     pred_taken_i,
  input  logic [frontend_pkg::FETCH_SLOT_BITS-1:0] pred_slot_i,
  input  logic [frontend_pkg::PLEN-1:0]            pred_target_i,
  input  logic                                     rsp_valid_i,
  input  logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::ILEN-1:0] rsp_data_i,
  output logic                                     ibuffer_valid_o,
  input  logic                                     ibuffer_ready_i,
  output logic [frontend_pkg::PLEN-1:0]            ibuffer_pc_o,
  output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::ILEN-1:0] ibuffer_data_o,
  output logic [frontend_pkg::FETCH_WIDTH-1:0]     ibuffer_slot_valid_o,
  output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::PLEN-1:0] ibuffer_pred_npc_o
);
  import frontend_pkg::*;

  logic [PLEN-1:0] fetch_pc_q;
  logic            boot_q;
  logic            issue_q;
  logic            wait_q;
  // Stored predictor answer
  logic                       pred_got_q;
  logic                       pred_taken_q;
  logic [FETCH_SLOT_BITS-1:0] pred_slot_q;
  logic [PLEN-1:0]            pred_target_q;

  logic                       use_taken;
  logic [FETCH_SLOT_BITS-1:0] use_slot;
  logic [PLEN-1:0]            use_target;
  logic [PLEN-1:0]            grp_base;
  logic [PLEN-1:0]            slot_pc;
  logic [PLEN-1:0]            next_pc;
  logic [FETCH_SLOT_BITS-1:0] start_slot;
  logic [FETCH_WIDTH-1:0]     slot_valid;
  logic [FETCH_WIDTH-1:0][PLEN-1:0] slot_npc;
  logic                       complete;
  logic                       accept;

  // Flush cancels a fetch in the same cycle
  assign fetch_req_o = issue_q && !flush_i;
  assign fetch_pc_o  = fetch_pc_q;
  assign kill_o      = flush_i;
  assign complete    = wait_q && rsp_valid_i && (pred_got_q || pred_valid_i);
  assign accept      = ibuffer_valid_o && ibuffer_ready_i;

  // ====================================================================
  // Group assembly
  // ====================================================================
  always_comb begin
    // Live answer wins when it lands with the cache data
    use_taken  = pred_valid_i ? pred_taken_i : pred_taken_q;
    use_slot   = pred_valid_i ? pred_slot_i : pred_slot_q;
    use_target = pred_valid_i ? pred_target_i : pred_target_q;
    grp_base   = {fetch_pc_q[PLEN-1:GROUP_OFFSET_BITS], {GROUP_OFFSET_BITS{1'b0}}};
    start_slot = fetch_pc_q[INSTR_BYTE_BITS +: FETCH_SLOT_BITS];
    next_pc    = use_taken ? use_target : grp_base + PLEN'(FETCH_BYTES);
    slot_pc    = grp_base;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      slot_pc = grp_base + (PLEN'(k) << INSTR_BYTE_BITS);
      // Valid from start slot through the taken slot
      slot_valid[k] = k >= int'(start_slot) && !(use_taken && k > int'(use_slot));
      slot_npc[k]   = (use_taken && k == int'(use_slot)) ? use_target :
                      slot_pc + PLEN'(INSTR_BYTES);
    end
  end

  // ====================================================================
  // Fetch control
  // ====================================================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_pc_q      <= RESET_PC;
      boot_q          <= 1'b1;
      issue_q         <= 1'b0;
      wait_q          <= 1'b0;
      pred_got_q      <= 1'b0;
      ibuffer_valid_o <= 1'b0;
    end else if (flush_i) begin
      // Drop held group and answers in flight
      fetch_pc_q      <= redirect_pc_i;
      boot_q          <= 1'b0;
      issue_q         <= 1'b1;
      wait_q          <= 1'b0;
      pred_got_q      <= 1'b0;
      ibuffer_valid_o <= 1'b0;
    end else begin
      boot_q <= 1'b0;
      if (boot_q)
        issue_q <= 1'b1;
      if (fetch_req_o) begin
        issue_q <= 1'b0;
        wait_q  <= 1'b1;
      end
      if (pred_valid_i)
        pred_got_q <= 1'b1;
      if (complete) begin
        wait_q          <= 1'b0;
        pred_got_q      <= 1'b0;
        ibuffer_valid_o <= 1'b1;
        fetch_pc_q      <= next_pc;
      end
      // Next request right after the handoff
      if (accept) begin
        ibuffer_valid_o <= 1'b0;
        issue_q         <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pred_valid_i) begin
      pred_taken_q  <= pred_taken_i;
      pred_slot_q   <= pred_slot_i;
      pred_target_q <= pred_target_i;
    end
  end

  // Group fields only load on completion, so they hold under back-pressure
  always_ff @(posedge clk_i) begin
    if (complete) begin
      ibuffer_pc_o         <= fetch_pc_q;
      ibuffer_data_o       <= rsp_data_i;
      ibuffer_slot_valid_o <= slot_valid;
      ibuffer_pred_npc_o   <= slot_npc;
    end
  end

endmodule : ifu

//--- source/icache.sv
// Direct-mapped instruction cache
module icache (
  input  logic                                                    clk_i,
  input  logic                                                    rst_i,
  input  logic                                                    fetch_req_i,
  input  logic [frontend_pkg::PLEN-1:0]                           fetch_pc_i,
  input  logic                                                    kill_i,
  output logic                                                    rsp_valid_o,
  output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::ILEN-1:0] rsp_data_o,
  output logic                                                    miss_req_valid_o,
  input  logic                                                    miss_req_ready_i,
  output logic [frontend_pkg::PLEN-1:0]                           miss_req_paddr_o,
  input  logic                                                    refill_valid_i,
  output logic                                                    refill_ready_o,
  input  logic [frontend_pkg::PLEN-1:0]                           refill_paddr_i,
  input  logic [frontend_pkg::LINE_BITS-1:0]                      refill_data_i
);
  import frontend_pkg::*;

  // Line storage
  logic [ICACHE_SETS-1:0]     line_valid_q;
  logic [ICACHE_TAG_BITS-1:0] tag_q  [ICACHE_SETS];
  logic [LINE_BITS-1:0]       data_q [ICACHE_SETS];

  logic [1:0]      state_q;
  logic [1:0]      state_d;
  logic [PLEN-1:0] req_pc_q;
  logic [PLEN-1:0] miss_addr_q;
  logic            killed_q;
  logic            pend_q;

  fetch_addr_u          req_addr;
  fetch_addr_u          refill_addr;
  logic [PLEN-1:0]      line_addr;
  logic [LINE_BITS-1:0] line;
  logic [ICACHE_WORD_BITS-FETCH_SLOT_BITS-1:0] grp_sel;
  logic                 hit;
  logic                 refill_fire;
  logic                 drop;

  // ====================================================================
  // Tag compare and group select
  // ====================================================================
  assign req_addr    = req_pc_q;
  assign refill_addr = refill_paddr_i;
  assign line_addr   = {req_addr.ic.tag, req_addr.ic.index, {ICACHE_OFFSET_BITS{1'b0}}};
  assign hit = line_valid_q[req_addr.ic.index] && tag_q[req_addr.ic.index] == req_addr.ic.tag;
  assign line    = data_q[req_addr.ic.index];
  // Which aligned pair inside the line
  assign grp_sel = req_addr.ic.word[ICACHE_WORD_BITS-1:FETCH_SLOT_BITS];
  assign rsp_data_o = line[grp_sel * (FETCH_WIDTH * ILEN) +: FETCH_WIDTH * ILEN];

  assign rsp_valid_o      = state_q == IC_LOOKUP && hit;
  // Raised right in the lookup cycle, unless the fetch is being killed
  assign miss_req_valid_o = (state_q == IC_LOOKUP && !hit && !kill_i) ||
                            state_q == IC_MISS_REQ;
  assign miss_req_paddr_o = state_q == IC_MISS_REQ ? miss_addr_q : line_addr;
  assign refill_ready_o   = state_q == IC_REFILL_WAIT;
  assign refill_fire      = refill_valid_i && refill_ready_o;
  assign drop             = killed_q || kill_i;

  // ====================================================================
  // Controller
  // ====================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IC_IDLE:
        if (fetch_req_i)
          state_d = IC_LOOKUP;
      IC_LOOKUP:
        if (hit || kill_i)
          state_d = IC_IDLE;
        else if (miss_req_ready_i)
          state_d = IC_REFILL_WAIT;
        else
          state_d = IC_MISS_REQ;
      IC_MISS_REQ:
        if (miss_req_ready_i)
          state_d = IC_REFILL_WAIT;
      default:
        // Relookup after refill, it hits unless a newer fetch replaced it
        if (refill_valid_i)
          state_d = (drop && !pend_q && !fetch_req_i) ? IC_IDLE : IC_LOOKUP;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= IC_IDLE;
      killed_q <= 1'b0;
      pend_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Killed fetch still finishes its refill
      if (refill_fire)
        killed_q <= 1'b0;
      else if (kill_i && (state_q == IC_MISS_REQ || state_q == IC_REFILL_WAIT))
        killed_q <= 1'b1;
      // New fetch waiting behind a refill
      if (refill_fire)
        pend_q <= 1'b0;
      else if (fetch_req_i && state_q != IC_IDLE)
        pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_req_i)
      req_pc_q <= fetch_pc_i;
    if (state_q == IC_LOOKUP)
      miss_addr_q <= line_addr;
  end

  // Refill write at the returned line address
  always_ff @(posedge clk_i) begin
    if (rst_i)
      line_valid_q <= '0;
    else if (refill_fire)
      line_valid_q[refill_addr.ic.index] <= 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (refill_fire) begin
      tag_q[refill_addr.ic.index]  <= refill_addr.ic.tag;
      data_q[refill_addr.ic.index] <= refill_data_i;
    end
  end

endmodule : icache

//--- source/bpu.sv
// Branch target buffer predictor
module bpu (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     fetch_req_i,
  input  logic [frontend_pkg::PLEN-1:0]            fetch_pc_i,
  input  logic                                     update_valid_i,
  input  logic [frontend_pkg::PLEN-1:0]            update_pc_i,
  input  logic                                     update_is_cond_i,
  input  logic                                     update_taken_i,
  input  logic [frontend_pkg::PLEN-1:0]            update_target_i,
  output logic                                     pred_valid_o,
  output logic                                     pred_taken_o,
  output logic [frontend_pkg::FETCH_SLOT_BITS-1:0] pred_slot_o,
  output logic [frontend_pkg::PLEN-1:0]            pred_target_o
);
  import frontend_pkg::*;

  // Entry storage, only the valid bits are cleared
  logic [BTB_ENTRIES-1:0]  btb_valid_q;
  logic [BTB_ENTRIES-1:0]  btb_cond_q;
  logic [BTB_TAG_BITS-1:0] btb_tag_q    [BTB_ENTRIES];
  logic [PLEN-1:0]         btb_target_q [BTB_ENTRIES];
  logic [1:0]              btb_ctr_q    [BTB_ENTRIES];

  fetch_addr_u                slot_addr;
  fetch_addr_u                upd_addr;
  logic [BTB_INDEX_BITS-1:0]  upd_idx;
  logic [PLEN-1:0]            grp_base;
  logic [FETCH_SLOT_BITS-1:0] start_slot;
  logic                       lkp_taken;
  logic [FETCH_SLOT_BITS-1:0] lkp_slot;
  logic [PLEN-1:0]            lkp_target;
  logic                       upd_hit;

  // ====================================================================
  // Lookup of every slot in the group
  // ====================================================================
  always_comb begin
    grp_base   = {fetch_pc_i[PLEN-1:GROUP_OFFSET_BITS], {GROUP_OFFSET_BITS{1'b0}}};
    start_slot = fetch_pc_i[INSTR_BYTE_BITS +: FETCH_SLOT_BITS];
    slot_addr  = '0;
    lkp_taken  = 1'b0;
    lkp_slot   = '0;
    lkp_target = '0;
    // Walk down so the lowest taken slot is the one left standing
    for (int k = FETCH_WIDTH - 1; k >= 0; k--) begin
      slot_addr = grp_base + (PLEN'(k) << INSTR_BYTE_BITS);
      if (k >= int'(start_slot) && btb_valid_q[slot_addr.bp.index] &&
          btb_tag_q[slot_addr.bp.index] == slot_addr.bp.tag &&
          (!btb_cond_q[slot_addr.bp.index] || btb_ctr_q[slot_addr.bp.index][1])) begin
        lkp_taken  = 1'b1;
        lkp_slot   = FETCH_SLOT_BITS'(k);
        lkp_target = btb_target_q[slot_addr.bp.index];
      end
    end
  end

  // Answer one cycle after the request
  always_ff @(posedge clk_i) begin
    if (rst_i)
      pred_valid_o <= 1'b0;
    else
      pred_valid_o <= fetch_req_i;
  end

  always_ff @(posedge clk_i) begin
    if (fetch_req_i) begin
      pred_taken_o  <= lkp_taken;
      pred_slot_o   <= lkp_slot;
      pred_target_o <= lkp_target;
    end
  end

  // ====================================================================
  // Training
  // ====================================================================
  assign upd_addr = update_pc_i;
  assign upd_idx  = upd_addr.bp.index;
  assign upd_hit  = btb_valid_q[upd_idx] && btb_tag_q[upd_idx] == upd_addr.bp.tag;

  always_ff @(posedge clk_i) begin
    if (rst_i)
      btb_valid_q <= '0;
    else if (update_valid_i && update_taken_i)
      btb_valid_q[upd_idx] <= 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (update_valid_i) begin
      if (upd_hit && btb_cond_q[upd_idx] && update_is_cond_i) begin
        // Existing conditional entry, saturating counter
        if (update_taken_i) begin
          btb_target_q[upd_idx] <= update_target_i;
          if (btb_ctr_q[upd_idx] != 2'd3)
            btb_ctr_q[upd_idx] <= btb_ctr_q[upd_idx] + 2'd1;
        end else if (btb_ctr_q[upd_idx] != 2'd0) begin
          btb_ctr_q[upd_idx] <= btb_ctr_q[upd_idx] - 2'd1;
        end
      end else if (update_taken_i) begin
        // Allocate or overwrite, weakly taken
        btb_tag_q[upd_idx]    <= upd_addr.bp.tag;
        btb_target_q[upd_idx] <= update_target_i;
        btb_cond_q[upd_idx]   <= update_is_cond_i;
        btb_ctr_q[upd_idx]    <= 2'd2;
      end
    end
  end

endmodule : bpu

//--- source/frontend_pkg.sv
// Fetch frontend shared definitions
package frontend_pkg;

  // ====================================================================
  // Datapath widths
  // ====================================================================
  localparam int unsigned PLEN            = 32;
  localparam int unsigned ILEN            = 32;
  localparam int unsigned INSTR_BYTES     = ILEN / 8;
  localparam int unsigned INSTR_BYTE_BITS = $clog2(INSTR_BYTES);
  // Two instructions per group, 8 aligned bytes
  localparam int unsigned FETCH_WIDTH       = 2;
  localparam int unsigned FETCH_SLOT_BITS   = $clog2(FETCH_WIDTH);
  localparam int unsigned FETCH_BYTES       = FETCH_WIDTH * INSTR_BYTES;
  localparam int unsigned GROUP_OFFSET_BITS = $clog2(FETCH_BYTES);
  localparam logic [PLEN-1:0] RESET_PC      = 32'h0000_1000;

  // ====================================================================
  // Cache and predictor geometry
  // ====================================================================
  localparam int unsigned LINE_BITS          = 128;
  localparam int unsigned ICACHE_SETS        = 16;
  localparam int unsigned ICACHE_INDEX_BITS  = $clog2(ICACHE_SETS);
  localparam int unsigned ICACHE_OFFSET_BITS = $clog2(LINE_BITS / 8);
  localparam int unsigned ICACHE_TAG_BITS    = PLEN - ICACHE_INDEX_BITS - ICACHE_OFFSET_BITS;
  localparam int unsigned ICACHE_WORD_BITS   = ICACHE_OFFSET_BITS - INSTR_BYTE_BITS;
  // One BTB entry per instruction address
  localparam int unsigned BTB_ENTRIES    = 16;
  localparam int unsigned BTB_INDEX_BITS = $clog2(BTB_ENTRIES);
  localparam int unsigned BTB_TAG_BITS   = PLEN - BTB_INDEX_BITS - INSTR_BYTE_BITS;

  // Cache controller states
  localparam logic [1:0] IC_IDLE        = 2'd0;
  localparam logic [1:0] IC_LOOKUP      = 2'd1;
  localparam logic [1:0] IC_MISS_REQ    = 2'd2;
  localparam logic [1:0] IC_REFILL_WAIT = 2'd3;

  // Fetch address, cache split and BTB split of the same word
  typedef union packed {
    struct packed {
      logic [ICACHE_TAG_BITS-1:0]   tag;
      logic [ICACHE_INDEX_BITS-1:0] index;
      logic [ICACHE_WORD_BITS-1:0]  word;
      logic [INSTR_BYTE_BITS-1:0]   byte_off;
    } ic;
    struct packed {
      logic [BTB_TAG_BITS-1:0]    tag;
      logic [BTB_INDEX_BITS-1:0]  index;
      logic [INSTR_BYTE_BITS-1:0] byte_off;
    } bp;
  } fetch_addr_u;

endpackage : frontend_pkg
